//--- rv_exec.f
+incdir+bench
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/control_unit.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/exec_pipe_reg.sv
verilog/rv_exec_top.sv
bench/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_ctrl_pkg.sv
      - verilog/control_unit.sv
      - verilog/imm_gen.sv
      - verilog/alu.sv
      - verilog/exec_pipe_reg.sv
      - verilog/rv_exec_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/rv_exec_tb.sv

//--- bench/rv_exec_vectors.svh
// Instruction vectors for the execute slice, included inside the testbench module
// Register fields in the encodings are fixed, operands arrive through rs1_i and rs2_i
`ifndef RV_EXEC_VECTORS_SVH
`define RV_EXEC_VECTORS_SVH

    localparam logic [3:0] F_RES = 4'b0001; // Compare result
    localparam logic [3:0] F_TGT = 4'b0010; // Compare target
    localparam logic [3:0] F_MEM = 4'b0100; // Compare mem_len, wb_sign, mem_wen_n
    localparam logic [3:0] F_WB  = 4'b1000; // Compare wb_sel
    localparam logic [3:0] CK_ALU = F_RES | F_WB;
    localparam logic [3:0] CK_JMP = F_RES | F_TGT;
    localparam logic [3:0] CK_LD  = F_RES | F_MEM | F_WB;
    localparam logic [3:0] CK_ST  = F_RES | F_MEM;

    // Expected control as {muldiv, rf_wen_n, wb_sel, mem_len, wb_sign, mem_wen_n, csr_wen_n}
    // muldiv packs start, sel and op
    localparam logic [11:0] CTL_ALU  = {4'h0, 1'b0, WB_ALU, LEN_BYTE, 1'b0, 1'b1, 1'b1};
    localparam logic [11:0] CTL_NONE = {4'h0, 1'b1, WB_ALU, LEN_BYTE, 1'b0, 1'b1, 1'b1};
    localparam logic [11:0] CTL_IMM  = {4'h0, 1'b0, WB_IMM, LEN_BYTE, 1'b0, 1'b1, 1'b1};
    localparam logic [11:0] CTL_CSR  = {4'h0, 1'b0, WB_ALU, LEN_BYTE, 1'b0, 1'b1, 1'b0};
    localparam logic [11:0] CTL_LB   = {4'h0, 1'b0, WB_MEM, LEN_BYTE, 1'b1, 1'b1, 1'b1};
    localparam logic [11:0] CTL_LHU  = {4'h0, 1'b0, WB_MEM, LEN_HALF, 1'b0, 1'b1, 1'b1};
    localparam logic [11:0] CTL_LW   = {4'h0, 1'b0, WB_MEM, LEN_WORD, 1'b1, 1'b1, 1'b1};
    localparam logic [11:0] CTL_SB   = {4'h0, 1'b1, WB_ALU, LEN_BYTE, 1'b0, 1'b0, 1'b1};
    localparam logic [11:0] CTL_SW   = {4'h0, 1'b1, WB_ALU, LEN_WORD, 1'b0, 1'b0, 1'b1};
    localparam logic [11:0] CTL_DIVU = {4'b1101, 1'b0, WB_ALU, LEN_BYTE, 1'b0, 1'b1, 1'b1};

    // Flags in the order illegal, ecall, ebreak, mret
    localparam logic [3:0] EX_NONE = 4'h0;
    localparam logic [3:0] EX_ILL  = 4'h8;
    localparam logic [3:0] EX_ECALL = 4'h4;
    localparam logic [3:0] EX_EBRK = 4'h2;
    localparam logic [3:0] EX_MRET = 4'h1;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] csr;
        logic [3:0]  chk;
        logic [31:0] result;
        logic        taken;
        logic [31:0] target;
        logic [11:0] ctl;
        logic [3:0]  exc;
    } vector_t;

    vector_t vectors[$];

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'd3, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    // CSR 0x300, source field is rs1 or the zimm value
    function automatic logic [31:0] csr_type(input logic [2:0] f3, input logic [4:0] src);
        return {12'h300, src, f3, 5'd3, OPC_SYSTEM};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] csr, input logic [3:0] chk,
                           input logic [31:0] result, input logic taken,
                           input logic [31:0] target, input logic [11:0] ctl,
                           input logic [3:0] exc);
        vectors.push_back('{instr, pc, rs1, rs2, csr, chk, result, taken, target, ctl, exc});
    endtask

    task automatic fill_vectors();
        add_row(r_type(7'h00, 3'd0, OPC_OP), 'h1000, 'h7, 'h5, 'h0,      // ADD
                CK_ALU, 'hc, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h20, 3'd0, OPC_OP), 'h1000, 'h5, 'h7, 'h0,      // SUB
                CK_ALU, 'hfffffffe, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h00, 3'd1, OPC_OP), 'h1000, 'h3, 'h24, 'h0,     // SLL, shamt 4
                CK_ALU, 'h30, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h00, 3'd5, OPC_OP), 'h1000, 'h80000000, 'h4, 'h0,
                CK_ALU, 'h08000000, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h20, 3'd5, OPC_OP), 'h1000, 'h80000000, 'h4, 'h0,
                CK_ALU, 'hf8000000, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h00, 3'd2, OPC_OP), 'h1000, 'hffffffff, 'h1, 'h0, // SLT
                CK_ALU, 'h1, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h00, 3'd3, OPC_OP), 'h1000, 'hffffffff, 'h1, 'h0, // SLTU
                CK_ALU, 'h0, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(i_type(12'hff0, 3'd0, OPC_OP_IMM), 'h1000, 'h20, 'h0, 'h0,
                CK_ALU, 'h10, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(i_type(12'h408, 3'd5, OPC_OP_IMM), 'h1000, 'hf0000000, 'h0, 'h0, // SRAI 8
                CK_ALU, 'hfff00000, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(r_type(7'h01, 3'd5, OPC_OP), 'h1000, 'h64, 'h7, 'h0,     // DIVU to the M unit
                F_WB, 'h0, 1'b0, 'h0, CTL_DIVU, EX_NONE);
        add_row(u_type(20'h12345, OPC_LUI), 'h1000, 'h0, 'h0, 'h0,
                CK_ALU, 'h12345000, 1'b0, 'h0, CTL_IMM, EX_NONE);
        add_row(u_type(20'h00001, OPC_AUIPC), 'h2000, 'h0, 'h0, 'h0,
                CK_ALU, 'h3000, 1'b0, 'h0, CTL_ALU, EX_NONE);
        add_row(b_type(13'h010, 3'd0), 'h1000, 'h5, 'h5, 'h0,            // BEQ
                F_TGT, 'h0, 1'b1, 'h1010, CTL_NONE, EX_NONE);
        add_row(b_type(13'h010, 3'd0), 'h1000, 'h5, 'h6, 'h0,
                F_TGT, 'h0, 1'b0, 'h1010, CTL_NONE, EX_NONE);
        add_row(b_type(13'h1ff0, 3'd1), 'h2000, 'h5, 'h6, 'h0,           // BNE backwards
                F_TGT, 'h0, 1'b1, 'h1ff0, CTL_NONE, EX_NONE);
        add_row(b_type(13'h010, 3'd4), 'h1000, 'hffffffff, 'h1, 'h0,     // BLT
                F_TGT, 'h0, 1'b1, 'h1010, CTL_NONE, EX_NONE);
        add_row(b_type(13'h010, 3'd5), 'h1000, 'hffffffff, 'h1, 'h0,     // BGE
                F_TGT, 'h0, 1'b0, 'h1010, CTL_NONE, EX_NONE);
        add_row(b_type(13'h010, 3'd6), 'h1000, 'hffffffff, 'h1, 'h0,     // BLTU
                F_TGT, 'h0, 1'b0, 'h1010, CTL_NONE, EX_NONE);
        add_row(b_type(13'h010, 3'd7), 'h1000, 'hffffffff, 'h1, 'h0,     // BGEU
                F_TGT, 'h0, 1'b1, 'h1010, CTL_NONE, EX_NONE);
        add_row(j_type(21'h000100), 'h1000, 'h0, 'h0, 'h0,
                CK_JMP, 'h1004, 1'b1, 'h1100, CTL_ALU, EX_NONE);
        add_row(j_type(21'h1ffff8), 'h2000, 'h0, 'h0, 'h0,
                CK_JMP, 'h2004, 1'b1, 'h1ff8, CTL_ALU, EX_NONE);
        add_row(i_type(12'h005, 3'd0, OPC_JALR), 'h1000, 'h2000, 'h0, 'h0, // Bit 0 cleared
                CK_JMP, 'h1004, 1'b1, 'h2004, CTL_ALU, EX_NONE);
        add_row(i_type(12'h004, 3'd0, OPC_LOAD), 'h1000, 'h100, 'h0, 'h0,  // LB
                CK_LD, 'h104, 1'b0, 'h0, CTL_LB, EX_NONE);
        add_row(i_type(12'hffc, 3'd5, OPC_LOAD), 'h1000, 'h100, 'h0, 'h0,  // LHU
                CK_LD, 'hfc, 1'b0, 'h0, CTL_LHU, EX_NONE);
        add_row(i_type(12'h008, 3'd2, OPC_LOAD), 'h1000, 'h200, 'h0, 'h0,  // LW
                CK_LD, 'h208, 1'b0, 'h0, CTL_LW, EX_NONE);
        add_row(s_type(12'h010, 3'd0), 'h1000, 'h300, 'h0, 'h0,          // SB
                CK_ST, 'h310, 1'b0, 'h0, CTL_SB, EX_NONE);
        add_row(s_type(12'hff8, 3'd2), 'h1000, 'h300, 'h0, 'h0,          // SW
                CK_ST, 'h2f8, 1'b0, 'h0, CTL_SW, EX_NONE);
        add_row(csr_type(3'd1, 5'd1), 'h1000, 'hf0f, 'h0, 'hff,          // CSRRW
                F_RES, 'hf0f, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row(csr_type(3'd2, 5'd1), 'h1000, 'hf0f, 'h0, 'hff,          // CSRRS
                F_RES, 'hfff, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row(csr_type(3'd3, 5'd1), 'h1000, 'hf0f, 'h0, 'hff,          // CSRRC
                F_RES, 'hf0, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row(csr_type(3'd5, 5'h15), 'h1000, 'hf0f, 'h0, 'hff,         // CSRRWI
                F_RES, 'h15, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row(csr_type(3'd6, 5'h0a), 'h1000, 'hf0f, 'h0, 'hf00,        // CSRRSI
                F_RES, 'hf0a, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row(csr_type(3'd7, 5'h0a), 'h1000, 'hf0f, 'h0, 'hff,         // CSRRCI
                F_RES, 'hf5, 1'b0, 'h0, CTL_CSR, EX_NONE);
        add_row('h00000073, 'h1000, 'h0, 'h0, 'h0,
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ECALL);
        add_row('h00100073, 'h1000, 'h0, 'h0, 'h0,
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_EBRK);
        add_row('h30200073, 'h1000, 'h0, 'h0, 'h0,
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_MRET);
        add_row('h00000000, 'h1000, 'h0, 'h0, 'h0,                      // All-zero word
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ILL);
        add_row(b_type(13'h010, 3'd2), 'h1000, 'h5, 'h6, 'h0,            // Reserved branch
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ILL);
        add_row(r_type(7'h20, 3'd1, OPC_OP), 'h1000, 'h1, 'h1, 'h0,
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ILL);
        add_row(csr_type(3'd4, 5'd1), 'h1000, 'h1, 'h0, 'h0,
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ILL);
        add_row(i_type(12'h000, 3'd3, OPC_LOAD), 'h1000, 'h0, 'h0, 'h0,  // RV64 LD
                4'h0, 'h0, 1'b0, 'h0, CTL_NONE, EX_ILL);
    endtask

`endif

//--- bench/rv_exec_tb.sv
// Table-driven testbench for the execute slice, inputs change on the falling edge
// Outputs are sampled on the falling edge and matched in issue order

`timescale 1ns/1ps

module rv_exec_tb
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
();

    localparam int RESET_CYCLES = 16;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr_rdata;
    logic            out_valid;
    ex_out_t         out;

    int unsigned cycle = 0;      // Rising edges seen so far
    int unsigned run_cycles = 0; // Rising edges since reset release
    int          timeout_limit;
    int          seed;
    int          pending_idx[$];
    int unsigned pending_due[$];

    `include "rv_exec_vectors.svh"

    rv_exec_top #(.XLEN(XLEN)) rv_exec_top_inst (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .valid_i     (in_valid),
        .instr_i     (instr),
        .pc_i        (pc),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .csr_rdata_i (csr_rdata),
        .valid_o     (out_valid),
        .out_o       (out)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (rst_n)
        begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= timeout_limit)
                stop_with_failure($sformatf("Timeout, results still missing after %0d cycles",
                                            run_cycles));
        end
    end

    task automatic check_outputs();
        vector_t v;
        int      idx;
        string   tag;
        if (!rst_n)
            compare("valid_o", 32'(out_valid), 32'h0); // Quiet during reset
        else if (out_valid)
        begin
            if (pending_idx.size() == 0)
                stop_with_failure("valid_o pulsed with no instruction in flight");
            idx = pending_idx.pop_front();
            tag = $sformatf("vector %0d ", idx);
            compare({tag, "valid_o cycle"}, cycle, pending_due.pop_front());
            v = vectors[idx];
            compare({tag, "out_o.exc"}, 32'(out.exc), 32'(v.exc));
            compare({tag, "out_o.taken"}, 32'(out.taken), 32'(v.taken));
            compare({tag, "out_o.ctrl.csr_wen_n"}, 32'(out.ctrl.csr_wen_n), 32'(v.ctl[0]));
            compare({tag, "out_o.ctrl.muldiv_start"}, 32'(out.ctrl.muldiv_start),
                    32'(v.ctl[11]));
            compare({tag, "out_o.ctrl.muldiv_sel"}, 32'(out.ctrl.muldiv_sel), 32'(v.ctl[10]));
            compare({tag, "out_o.ctrl.muldiv_op"}, 32'(out.ctrl.muldiv_op), 32'(v.ctl[9:8]));
            if (v.exc != EX_ILL)
                compare({tag, "out_o.ctrl.rf_wen_n"}, 32'(out.ctrl.rf_wen_n), 32'(v.ctl[7]));
            if (v.chk & F_RES)
                compare({tag, "out_o.result"}, out.result, v.result);
            if (v.chk & F_TGT)
                compare({tag, "out_o.target"}, out.target, v.target);
            if (v.chk & F_WB)
                compare({tag, "out_o.ctrl.wb_sel"}, 32'(out.ctrl.wb_sel), 32'(v.ctl[6:5]));
            if (v.chk & F_MEM)
            begin
                compare({tag, "out_o.ctrl.mem_len"}, 32'(out.ctrl.mem_len), 32'(v.ctl[4:3]));
                compare({tag, "out_o.ctrl.wb_sign"}, 32'(out.ctrl.wb_sign), 32'(v.ctl[2]));
                compare({tag, "out_o.ctrl.mem_wen_n"}, 32'(out.ctrl.mem_wen_n), 32'(v.ctl[1]));
            end
        end
        else if (pending_due.size() != 0 && pending_due[0] <= cycle)
            stop_with_failure($sformatf("No valid_o for vector %0d at its due cycle",
                                        pending_idx[0]));
    endtask

    task automatic drive(input int idx);
        in_valid  = 1'b1;
        instr     = vectors[idx].instr;
        pc        = vectors[idx].pc;
        rs1       = vectors[idx].rs1;
        rs2       = vectors[idx].rs2;
        csr_rdata = vectors[idx].csr;
    endtask

    initial
    begin
        int n;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1       = '0;
        rs2       = '0;
        csr_rdata = '0;
        seed      = 11;
        fill_vectors();
        timeout_limit = 2 * vectors.size() + 40;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;
        n = 0;
        while (n < vectors.size())
        begin
            @(negedge clk);
            check_outputs();
            if (($random(seed) & 3) != 0)
            begin
                drive(n);
                pending_idx.push_back(n);
                pending_due.push_back(cycle + 2); // Two rising edges later
                n++;
            end
            else
            begin
                in_valid = 1'b0;
                instr    = $random(seed); // Junk the slice must ignore
            end
        end
        while (pending_idx.size() != 0)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            check_outputs();
        end
        repeat (3) // No stray pulses after the last result
        begin
            @(negedge clk);
            check_outputs();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog/rv_exec_top.sv
// Decode and execute slice, fixed two-cycle latency from valid_i to valid_o
// No back-pressure, the consumer must take every valid_o pulse

`timescale 1ns/1ps

module rv_exec_top
    import rv_ctrl_pkg::*;
#(
    parameter int XLEN = 32
)
(
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    input  logic [31:0]      instr_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [XLEN-1:0]  rs1_i,
    input  logic [XLEN-1:0]  rs2_i,
    input  logic [XLEN-1:0]  csr_rdata_i,
    output logic             valid_o,
    output ex_out_t          out_o
);

    ctrl_t           dec_ctrl;
    exc_t            dec_exc;
    logic [XLEN-1:0] dec_imm;
    logic [XLEN-1:0] dec_zimm;
    ex_in_t          s1_in;
    ex_in_t          s1_q;
    logic            s1_valid;
    logic [XLEN-1:0] ex_result;
    logic [XLEN-1:0] ex_target;
    logic            ex_taken;
    ex_out_t         s2_in;

    if (XLEN != rv_ctrl_pkg::XLEN)
    begin : g_xlen_check
        $error("XLEN must match the stage record width");
    end

    control_unit control_unit_inst (
        .instr_i (instr_i),
        .ctrl_o  (dec_ctrl),
        .exc_o   (dec_exc)
    );

    imm_gen imm_gen_inst (
        .instr_i (instr_i),
        .imm_o   (dec_imm),
        .zimm_o  (dec_zimm)
    );

    assign s1_in = '{ctrl: dec_ctrl, exc: dec_exc, pc: pc_i, rs1: rs1_i, rs2: rs2_i,
                     imm: dec_imm, zimm: dec_zimm, csr_rdata: csr_rdata_i};

    exec_pipe_reg #(.payload_t(ex_in_t)) stage1_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .data_i  (s1_in),
        .valid_o (s1_valid),
        .data_o  (s1_q)
    );

    alu #(.XLEN(XLEN)) alu_inst (
        .ex_i     (s1_q),
        .result_o (ex_result),
        .taken_o  (ex_taken),
        .target_o (ex_target)
    );

    assign s2_in = '{ctrl: s1_q.ctrl, exc: s1_q.exc, result: ex_result,
                     taken: ex_taken, target: ex_target};

    exec_pipe_reg #(.payload_t(ex_out_t)) stage2_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (s1_valid),
        .data_i  (s2_in),
        .valid_o (valid_o),
        .data_o  (out_o)
    );

endmodule

//--- verilog/exec_pipe_reg.sv
// One pipeline stage, payload only loads while valid_i is high
// No stall input, every stage advances each cycle

`timescale 1ns/1ps

module exec_pipe_reg #(
    parameter type payload_t = logic
)
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            data_o <= '0;
        else if (valid_i)
            data_o <= data_i; // Holds last payload through bubbles
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o |-> !$isunknown(data_o))
        else $error("pipeline payload has unknown bits while valid");

endmodule

//--- verilog/alu.sv
// Single-cycle execute datapath, no carry or overflow flags
// Shift amounts use the low log2(XLEN) bits of operand B

`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
#(
    parameter int XLEN = 32
)
(
    input  ex_in_t           ex_i,
    output logic [XLEN-1:0]  result_o,
    output logic             taken_o,
    output logic [XLEN-1:0]  target_o
);

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] jalr_sum;

    always_comb
    begin
        case (ex_i.ctrl.opa_sel)
            OPA_PC:   op_a = ex_i.pc;
            OPA_ZIMM: op_a = (ex_i.ctrl.alu_mod == MOD_INVERT_ZIMM) ? ~ex_i.zimm : ex_i.zimm;
            default:  op_a = ex_i.rs1;
        endcase
        if (ex_i.ctrl.alu_mod == MOD_INVERT_A)
            op_a = ~op_a; // CSRRC clear mask
        case (ex_i.ctrl.opb_sel)
            OPB_IMM: op_b = ex_i.imm;
            OPB_CSR: op_b = ex_i.csr_rdata;
            default: op_b = ex_i.rs2;
        endcase
    end

    assign shamt = op_b[SHW-1:0];

    always_comb
    begin
        case (ex_i.ctrl.alu_func)
            ALU_ADD:  result_o = op_a + op_b;
            ALU_SUB:  result_o = op_a - op_b;
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            ALU_SLTU: result_o = XLEN'(op_a < op_b);
            ALU_SLT:  result_o = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL:  result_o = op_a << shamt;
            ALU_SRL:  result_o = op_a >> shamt;
            ALU_SRA:  result_o = $signed(op_a) >>> shamt;
            ALU_EQ:   result_o = XLEN'(op_a == op_b);
            ALU_NE:   result_o = XLEN'(op_a != op_b);
            ALU_GEU:  result_o = XLEN'(op_a >= op_b);
            ALU_GE:   result_o = XLEN'($signed(op_a) >= $signed(op_b));
            ALU_LINK: result_o = ex_i.pc + XLEN'(4);
            default:  result_o = op_b; // PASS_B
        endcase
    end

    // Branch compares leave their outcome in bit 0
    assign taken_o  = ex_i.ctrl.is_jump | (ex_i.ctrl.is_branch & result_o[0]);
    assign jalr_sum = ex_i.rs1 + ex_i.imm;
    assign target_o = ex_i.ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : ex_i.pc + ex_i.imm;

endmodule

//--- verilog/imm_gen.sv
// Immediate builder, format picked from the opcode alone
// OP and SYSTEM give a zero immediate, CSR writes rely on that

`timescale 1ns/1ps

module imm_gen
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic [31:0]      instr_i,
    output logic [XLEN-1:0]  imm_o,
    output logic [XLEN-1:0]  zimm_o
);

    always_comb
    begin
        case (instr_i[6:0])
            OPC_LOAD, OPC_OP_IMM, OPC_JALR:
                imm_o = XLEN'($signed(instr_i[31:20]));
            OPC_STORE:
                imm_o = XLEN'($signed({instr_i[31:25], instr_i[11:7]}));
            OPC_BRANCH:
                imm_o = XLEN'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                       instr_i[11:8], 1'b0}));
            OPC_LUI, OPC_AUIPC:
                imm_o = XLEN'($signed({instr_i[31:12], 12'b0}));
            OPC_JAL:
                imm_o = XLEN'($signed({instr_i[31], instr_i[19:12], instr_i[20],
                                       instr_i[30:21], 1'b0}));
            default:
                imm_o = '0;
        endcase
    end

    assign zimm_o = XLEN'(instr_i[19:15]); // rs1 field as CSR immediate

endmodule

//--- verilog/control_unit.sv
// Purely combinational RV32I, Zicsr and M decoder
// Reserved encodings only raise the illegal flag, nothing is squashed downstream

`timescale 1ns/1ps

module control_unit
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic [31:0] instr_i,
    output ctrl_t       ctrl_o,
    output exc_t        exc_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ecall;
    logic       is_ebreak;
    logic       is_mret;
    logic       illegal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    function automatic mem_len_t len_of(input logic [1:0] size);
        case (size)
            2'b00:   len_of = LEN_BYTE;
            2'b01:   len_of = LEN_HALF;
            default: len_of = LEN_WORD;
        endcase
    endfunction

    always_comb
    begin
        ctrl_o           = '0; // ADD, rs1/rs2 operands, ALU writeback
        ctrl_o.mem_wen_n = 1'b1;
        ctrl_o.rf_wen_n  = 1'b1;
        ctrl_o.csr_wen_n = 1'b1;
        case (opcode)
            OPC_BRANCH:
            begin
                ctrl_o.is_branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.alu_func = ALU_EQ;
                    3'b001:  ctrl_o.alu_func = ALU_NE;
                    3'b100:  ctrl_o.alu_func = ALU_SLT;
                    3'b101:  ctrl_o.alu_func = ALU_GE;
                    3'b110:  ctrl_o.alu_func = ALU_SLTU;
                    3'b111:  ctrl_o.alu_func = ALU_GEU;
                    default: ctrl_o.is_branch = 1'b0; // Reserved compare
                endcase
            end
            OPC_LUI:
            begin
                ctrl_o.rf_wen_n = 1'b0;
                ctrl_o.wb_sel   = WB_IMM;
                ctrl_o.opb_sel  = OPB_IMM;
                ctrl_o.alu_func = ALU_PASS_B;
            end
            OPC_AUIPC:
            begin
                ctrl_o.rf_wen_n = 1'b0;
                ctrl_o.opa_sel  = OPA_PC;
                ctrl_o.opb_sel  = OPB_IMM;
            end
            OPC_JAL, OPC_JALR:
            begin
                ctrl_o.rf_wen_n = 1'b0;
                ctrl_o.is_jump  = 1'b1;
                ctrl_o.jalr     = (opcode == OPC_JALR);
                ctrl_o.opa_sel  = OPA_PC;
                ctrl_o.alu_func = ALU_LINK; // Link address to rd
            end
            OPC_LOAD:
            begin
                ctrl_o.rf_wen_n = 1'b0;
                ctrl_o.wb_sel   = WB_MEM;
                ctrl_o.wb_sign  = !funct3[2];
                ctrl_o.mem_len  = len_of(funct3[1:0]);
                ctrl_o.opb_sel  = OPB_IMM;
            end
            OPC_STORE:
            begin
                ctrl_o.mem_wen_n = funct3[2] | (funct3[1:0] == 2'b11);
                ctrl_o.mem_len   = len_of(funct3[1:0]);
                ctrl_o.opb_sel   = OPB_IMM;
            end
            OPC_OP_IMM, OPC_OP:
            begin
                ctrl_o.rf_wen_n = 1'b0;
                if (opcode[5])
                    ctrl_o.opb_sel = OPB_RS2;
                else
                    ctrl_o.opb_sel = OPB_IMM;
                case (funct3)
                    3'b000:
                    begin
                        if (opcode[5] && funct7[5])
                            ctrl_o.alu_func = ALU_SUB;
                        else
                            ctrl_o.alu_func = ALU_ADD;
                    end
                    3'b001: ctrl_o.alu_func = ALU_SLL;
                    3'b010: ctrl_o.alu_func = ALU_SLT;
                    3'b011: ctrl_o.alu_func = ALU_SLTU;
                    3'b100: ctrl_o.alu_func = ALU_XOR;
                    3'b101:
                    begin
                        if (funct7[5])
                            ctrl_o.alu_func = ALU_SRA;
                        else
                            ctrl_o.alu_func = ALU_SRL;
                    end
                    3'b110: ctrl_o.alu_func = ALU_OR;
                    default: ctrl_o.alu_func = ALU_AND;
                endcase
                if (opcode == OPC_OP && funct7 == 7'd1)
                begin
                    ctrl_o.muldiv_start = 1'b1; // Handed to the external M unit
                    ctrl_o.muldiv_sel   = funct3[2];
                    ctrl_o.muldiv_op    = funct3[1:0];
                end
            end
            OPC_SYSTEM:
            begin
                if (funct3[1:0] != 2'b00)
                begin
                    ctrl_o.rf_wen_n  = 1'b0;
                    ctrl_o.csr_wen_n = 1'b0;
                    if (funct3[2])
                        ctrl_o.opa_sel = OPA_ZIMM;
                    else
                        ctrl_o.opa_sel = OPA_RS1;
                    case (funct3[1:0])
                        2'b01:
                        begin
                            ctrl_o.opb_sel  = OPB_IMM; // Zero for SYSTEM, so OR passes A
                            ctrl_o.alu_func = ALU_OR;
                        end
                        2'b10:
                        begin
                            ctrl_o.opb_sel  = OPB_CSR;
                            ctrl_o.alu_func = ALU_OR;
                        end
                        default:
                        begin
                            ctrl_o.opb_sel  = OPB_CSR;
                            ctrl_o.alu_func = ALU_AND;
                            if (funct3[2])
                                ctrl_o.alu_mod = MOD_INVERT_ZIMM;
                            else
                                ctrl_o.alu_mod = MOD_INVERT_A;
                        end
                    endcase
                end
            end
            default:
            begin
            end
        endcase
    end

    assign is_ecall  = (instr_i == 32'h0000_0073);
    assign is_ebreak = (instr_i == 32'h0010_0073);
    assign is_mret   = (instr_i == 32'h3020_0073);

    always_comb
    begin
        case (opcode)
            OPC_BRANCH: illegal = (funct3[2:1] == 2'b01);
            OPC_LUI, OPC_AUIPC, OPC_JAL: illegal = 1'b0;
            OPC_JALR:   illegal = (funct3 != 3'd0);
            OPC_LOAD:   illegal = (funct3 == 3'd3) || (funct3[2:1] == 2'b11);
            OPC_STORE:  illegal = funct3[2] || (funct3[1:0] == 2'b11);
            OPC_OP:
            begin
                if (funct7 == 7'd1)
                    illegal = 1'b0;
                else if (funct3 == 3'd0 || funct3 == 3'd5)
                    illegal = {funct7[6], funct7[4:0]} != 6'd0; // Only bit 30 may be set
                else
                    illegal = (funct7 != 7'd0);
            end
            OPC_OP_IMM:
            begin
                if (funct3 == 3'd1)
                    illegal = (funct7 != 7'd0);
                else if (funct3 == 3'd5)
                    illegal = {funct7[6], funct7[4:0]} != 6'd0;
                else
                    illegal = 1'b0;
            end
            OPC_SYSTEM:
                illegal = (funct3 == 3'b100)
                          || (funct3 == 3'b000 && !(is_ecall || is_ebreak || is_mret));
            default:    illegal = 1'b1;
        endcase
    end

    assign exc_o = '{illegal: illegal, ecall: is_ecall, ebreak: is_ebreak, mret: is_mret};

    // The decode and illegal blocks are written apart and must agree
    always_comb
    begin
        assert final (!(illegal && (!ctrl_o.mem_wen_n || ctrl_o.is_branch)))
            else $error("illegal instruction decoded as store or branch");
    end

endmodule

//--- verilog/rv_ctrl_pkg.sv
// Records passed between the decode, execute and pipeline stages
// Write enables are active low, so an all-zero ctrl_t is not a safe bubble
package rv_ctrl_pkg;
    import rv_isa_pkg::*;

    localparam int XLEN = 32;

    typedef struct packed {
        alu_func_t  alu_func;
        alu_mod_t   alu_mod;
        opa_sel_t   opa_sel;
        opb_sel_t   opb_sel;
        logic       is_branch;
        logic       is_jump;
        logic       jalr;        // Target from rs1 instead of pc
        mem_len_t   mem_len;
        logic       mem_wen_n;
        logic       rf_wen_n;
        logic       csr_wen_n;
        wb_sel_t    wb_sel;
        logic       wb_sign;     // Sign-extend load data
        logic       muldiv_start;
        logic       muldiv_sel;  // 1 selects the divider
        logic [1:0] muldiv_op;
    } ctrl_t;

    typedef struct packed {
        logic illegal;
        logic ecall;
        logic ebreak;
        logic mret;
    } exc_t;

    typedef struct packed {
        ctrl_t            ctrl;
        exc_t             exc;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  zimm;
        logic [XLEN-1:0]  csr_rdata;
    } ex_in_t;

    typedef struct packed {
        ctrl_t            ctrl;
        exc_t             exc;
        logic [XLEN-1:0]  result;
        logic             taken;
        logic [XLEN-1:0]  target;
    } ex_out_t;

endpackage

//--- verilog/rv_isa_pkg.sv
// Encodings for the RV32I, Zicsr and M subset decoded by the execute slice
// FENCE and compressed forms are not decoded and fall into the illegal path
package rv_isa_pkg;

    localparam logic [6:0] OPC_LOAD   = 7'b00000_11;
    localparam logic [6:0] OPC_STORE  = 7'b01000_11;
    localparam logic [6:0] OPC_BRANCH = 7'b11000_11;
    localparam logic [6:0] OPC_JAL    = 7'b11011_11;
    localparam logic [6:0] OPC_JALR   = 7'b11001_11;
    localparam logic [6:0] OPC_OP_IMM = 7'b00100_11;
    localparam logic [6:0] OPC_OP     = 7'b01100_11; // Also carries M with funct7 of 1
    localparam logic [6:0] OPC_LUI    = 7'b01101_11;
    localparam logic [6:0] OPC_AUIPC  = 7'b00101_11;
    localparam logic [6:0] OPC_SYSTEM = 7'b11100_11;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_XOR    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_AND    = 4'd4,
        ALU_SLTU   = 4'd5,
        ALU_SLT    = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_EQ     = 4'd10,
        ALU_NE     = 4'd11,
        ALU_GEU    = 4'd12,
        ALU_GE     = 4'd13,
        ALU_LINK   = 4'd14, // pc plus 4
        ALU_PASS_B = 4'd15
    } alu_func_t;

    typedef enum logic [1:0] {MOD_NONE, MOD_INVERT_A, MOD_INVERT_ZIMM} alu_mod_t;
    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZIMM} opa_sel_t;
    typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_CSR} opb_sel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM} wb_sel_t;
    typedef enum logic [1:0] {LEN_BYTE, LEN_HALF, LEN_WORD} mem_len_t;

endpackage
